// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000; // first fetch address

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // srl and sra
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // selects sub and sra

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B  // lui result comes straight from op2
    } alu_op_e;

endpackage

// File: src/rv_core_pkg.sv
package rv_core_pkg;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE
    } ctrl_state_e;

    // decoder output, registered by the fsm in DECODE
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::XLEN-1:0]       op1;
        logic [rv_isa_pkg::XLEN-1:0]       op2;
        rv_isa_pkg::alu_op_e               alu_op;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                              wen;
        logic                              is_branch;
        logic                              is_jump;
        logic [2:0]                        br_funct3;
        logic [rv_isa_pkg::XLEN-1:0]       base_addr;   // target base
        logic [rv_isa_pkg::XLEN-1:0]       offset_addr; // target offset
    } decoded_t;

    // one completed instruction
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        logic                              wen;
        logic [rv_isa_pkg::XLEN-1:0]       wdata;
        logic [rv_isa_pkg::XLEN-1:0]       next_pc;
    } retire_t;

endpackage

// File: src/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic [31:0]           inst_i,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           rs1_data_i,
    input  logic [31:0]           rs2_data_i,
    output logic [4:0]            rs1_addr_o,
    output logic [4:0]            rs2_addr_o,
    output rv_core_pkg::decoded_t dec_o
);

    rv_isa_pkg::opcode_e opcode;
    logic [4:0]          rd;
    logic [2:0]          funct3;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [6:0]          funct7;
    logic [31:0]         imm_i;
    logic [31:0]         imm_u;
    logic [31:0]         imm_b;
    logic [31:0]         imm_j;

    // funct3 to alu operation, alt only counts for sub on register ops
    function automatic rv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                    input logic reg_op);
        rv_isa_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = (alt && reg_op) ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::SLL;
            rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::XOR;
            rv_isa_pkg::F3_SR:      op = alt ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
            rv_isa_pkg::F3_OR:      op = rv_isa_pkg::OR;
            default:                op = rv_isa_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20]; // also shamt for immediate shifts
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        // unknown encodings fall through as a no-op
        rs1_addr_o        = 5'b0;
        rs2_addr_o        = 5'b0;
        dec_o             = '0;
        dec_o.pc          = pc_i;
        dec_o.alu_op      = rv_isa_pkg::ADD;
        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                rs1_addr_o   = rs1;
                dec_o.op1    = rs1_data_i;
                dec_o.alu_op = alu_sel(funct3, funct7 == rv_isa_pkg::F7_ALT, 1'b0);
                if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SR) begin
                    dec_o.op2 = {27'b0, rs2};
                end else begin
                    dec_o.op2 = imm_i;
                end
                dec_o.rd     = rd;
                dec_o.wen    = 1'b1;
            end
            rv_isa_pkg::OP: begin
                rs1_addr_o   = rs1;
                rs2_addr_o   = rs2;
                dec_o.op1    = rs1_data_i;
                dec_o.alu_op = alu_sel(funct3, funct7 == rv_isa_pkg::F7_ALT, 1'b1);
                if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SR) begin
                    dec_o.op2 = {27'b0, rs2_data_i[4:0]}; // shift by 5 bits at most
                end else begin
                    dec_o.op2 = rs2_data_i;
                end
                dec_o.rd     = rd;
                dec_o.wen    = 1'b1;
            end
            rv_isa_pkg::BRANCH: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    rs1_addr_o        = rs1;
                    rs2_addr_o        = rs2;
                    dec_o.op1         = rs1_data_i;
                    dec_o.op2         = rs2_data_i;
                    dec_o.is_branch   = 1'b1;
                    dec_o.br_funct3   = funct3;
                    dec_o.base_addr   = pc_i;
                    dec_o.offset_addr = imm_b;
                end
            end
            rv_isa_pkg::JAL: begin
                dec_o.op1         = pc_i; // link value pc + 4
                dec_o.op2         = 32'h4;
                dec_o.rd          = rd;
                dec_o.wen         = 1'b1;
                dec_o.is_jump     = 1'b1;
                dec_o.base_addr   = pc_i;
                dec_o.offset_addr = imm_j;
            end
            rv_isa_pkg::JALR: begin
                rs1_addr_o        = rs1;
                dec_o.op1         = pc_i;
                dec_o.op2         = 32'h4;
                dec_o.rd          = rd;
                dec_o.wen         = 1'b1;
                dec_o.is_jump     = 1'b1;
                dec_o.base_addr   = rs1_data_i;
                dec_o.offset_addr = imm_i;
            end
            rv_isa_pkg::LUI: begin
                dec_o.op2    = imm_u;
                dec_o.alu_op = rv_isa_pkg::PASS_B;
                dec_o.rd     = rd;
                dec_o.wen    = 1'b1;
            end
            rv_isa_pkg::AUIPC: begin
                dec_o.op1         = pc_i;
                dec_o.op2         = imm_u;
                dec_o.rd          = rd;
                dec_o.wen         = 1'b1;
            end
            default: begin
                dec_o.wen = 1'b0;
            end
        endcase
    end

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_isa_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_isa_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                              wen_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i
);

    logic [rv_isa_pkg::XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin // x0 is never written
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, x0 forced to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: src/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::decoded_t dec_i,
    output rv_core_pkg::retire_t  retire_o
);

    logic [rv_isa_pkg::XLEN-1:0] alu_res;
    logic [rv_isa_pkg::XLEN-1:0] target;
    logic [rv_isa_pkg::XLEN-1:0] seq_pc;
    logic                        taken;

    always_comb begin
        case (dec_i.alu_op)
            rv_isa_pkg::ADD:    alu_res = dec_i.op1 + dec_i.op2;
            rv_isa_pkg::SUB:    alu_res = dec_i.op1 - dec_i.op2;
            rv_isa_pkg::SLL:    alu_res = dec_i.op1 << dec_i.op2[4:0];
            rv_isa_pkg::SLT:    alu_res = {31'b0, $signed(dec_i.op1) < $signed(dec_i.op2)};
            rv_isa_pkg::SLTU:   alu_res = {31'b0, dec_i.op1 < dec_i.op2};
            rv_isa_pkg::XOR:    alu_res = dec_i.op1 ^ dec_i.op2;
            rv_isa_pkg::SRL:    alu_res = dec_i.op1 >> dec_i.op2[4:0];
            rv_isa_pkg::SRA:    alu_res = $unsigned($signed(dec_i.op1) >>> dec_i.op2[4:0]);
            rv_isa_pkg::OR:     alu_res = dec_i.op1 | dec_i.op2;
            rv_isa_pkg::AND:    alu_res = dec_i.op1 & dec_i.op2;
            rv_isa_pkg::PASS_B: alu_res = dec_i.op2;
            default:            alu_res = '0;
        endcase
    end

    // branch condition on the two register operands
    always_comb begin
        case (dec_i.br_funct3)
            rv_isa_pkg::F3_BEQ:  taken = (dec_i.op1 == dec_i.op2);
            rv_isa_pkg::F3_BNE:  taken = (dec_i.op1 != dec_i.op2);
            rv_isa_pkg::F3_BLT:  taken = ($signed(dec_i.op1) < $signed(dec_i.op2));
            rv_isa_pkg::F3_BGE:  taken = ($signed(dec_i.op1) >= $signed(dec_i.op2));
            rv_isa_pkg::F3_BLTU: taken = (dec_i.op1 < dec_i.op2);
            rv_isa_pkg::F3_BGEU: taken = (dec_i.op1 >= dec_i.op2);
            default:             taken = 1'b0;
        endcase
    end

    assign target = dec_i.base_addr + dec_i.offset_addr;
    assign seq_pc = dec_i.pc + 32'h4;

    always_comb begin
        retire_o.pc    = dec_i.pc;
        retire_o.rd    = dec_i.rd;
        retire_o.wen   = dec_i.wen;
        retire_o.wdata = alu_res;
        if (dec_i.is_jump || (dec_i.is_branch && taken)) begin
            // bit 0 cleared for jalr, jal and branch targets are even anyway
            retire_o.next_pc = {target[rv_isa_pkg::XLEN-1:1], 1'b0};
        end else begin
            retire_o.next_pc = seq_pc;
        end
    end

endmodule

// File: src/rv_ctrl_fsm.sv
`timescale 1ns/1ps

module rv_ctrl_fsm (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    output logic                  fetch_valid_o,
    output logic [31:0]           fetch_addr_o,
    input  logic                  fetch_ready_i,
    input  logic [31:0]           fetch_inst_i,
    output logic [31:0]           inst_o,
    output logic [31:0]           pc_o,
    input  rv_core_pkg::decoded_t dec_i,
    output rv_core_pkg::decoded_t dec_q_o,
    input  rv_core_pkg::retire_t  exe_i,
    output logic                  rf_wen_o,
    output logic                  retire_valid_o,
    output rv_core_pkg::retire_t  retire_o
);

    rv_core_pkg::ctrl_state_e state_q;
    rv_core_pkg::ctrl_state_e state_d;
    logic [31:0]              pc_q;
    logic [31:0]              inst_q;
    rv_core_pkg::decoded_t    dec_q;
    logic                     fetch_fire;

    assign fetch_valid_o = (state_q == rv_core_pkg::FETCH);
    assign fetch_fire    = fetch_valid_o && fetch_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_core_pkg::FETCH:   if (fetch_fire) state_d = rv_core_pkg::DECODE; // wait on ready
            rv_core_pkg::DECODE:  state_d = rv_core_pkg::EXECUTE;
            rv_core_pkg::EXECUTE: state_d = rv_core_pkg::FETCH;
            default:              state_d = rv_core_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= rv_core_pkg::FETCH;
            pc_q    <= rv_isa_pkg::RESET_PC;
        end else begin
            state_q <= state_d;
            if (state_q == rv_core_pkg::EXECUTE) begin
                pc_q <= exe_i.next_pc;
            end
        end
    end

    // instruction and decoded operands
    always_ff @(posedge clk_i) begin
        if (fetch_fire) begin
            inst_q <= fetch_inst_i;
        end
        if (state_q == rv_core_pkg::DECODE) begin
            dec_q <= dec_i;
        end
    end

    assign fetch_addr_o   = pc_q; // held while ready is low
    assign inst_o         = inst_q;
    assign pc_o           = pc_q;
    assign dec_q_o        = dec_q;
    assign rf_wen_o       = (state_q == rv_core_pkg::EXECUTE) && exe_i.wen;
    assign retire_valid_o = (state_q == rv_core_pkg::EXECUTE);
    assign retire_o       = exe_i;

endmodule

// File: src/rv_event_counter.sv
`timescale 1ns/1ps

module rv_event_counter (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        retire_i,
    output logic [31:0] cycle_count_o,
    output logic [31:0] instret_count_o
);

    logic [31:0] cycle_q;
    logic [31:0] instret_q;

    // both wrap silently at 2^32
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q <= cycle_q + 32'd1;
            if (retire_i) begin
                instret_q <= instret_q + 32'd1;
            end
        end
    end

    assign cycle_count_o   = cycle_q;
    assign instret_count_o = instret_q;

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    output logic                 fetch_valid_o,
    output logic [31:0]          fetch_addr_o,
    input  logic                 fetch_ready_i,
    input  logic [31:0]          fetch_inst_i,
    output logic                 retire_valid_o,
    output rv_core_pkg::retire_t retire_o,
    output logic [31:0]          cycle_count_o,
    output logic [31:0]          instret_count_o
);

    logic [31:0]           inst;
    logic [31:0]           pc;
    logic [4:0]            rs1_addr;
    logic [4:0]            rs2_addr;
    logic [31:0]           rs1_data;
    logic [31:0]           rs2_data;
    rv_core_pkg::decoded_t dec;
    rv_core_pkg::decoded_t dec_q;
    rv_core_pkg::retire_t  exe;
    logic                  rf_wen;

    rv_ctrl_fsm i_ctrl_fsm (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_ready_i  (fetch_ready_i),
        .fetch_inst_i   (fetch_inst_i),
        .inst_o         (inst),
        .pc_o           (pc),
        .dec_i          (dec),
        .dec_q_o        (dec_q),
        .exe_i          (exe),
        .rf_wen_o       (rf_wen),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    rv_decode i_decode (
        .inst_i     (inst),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_o      (dec)
    );

    rv_regfile i_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (rf_wen),
        .waddr_i    (exe.rd),    // writeback straight from execute
        .wdata_i    (exe.wdata)
    );

    rv_execute i_execute (
        .dec_i    (dec_q),
        .retire_o (exe)
    );

    rv_event_counter i_event_counter (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .retire_i        (retire_valid_o),
        .cycle_count_o   (cycle_count_o),
        .instret_count_o (instret_count_o)
    );

endmodule

// File: verification/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        fetch_valid_i,
    input logic [31:0] fetch_addr_i,
    input logic        fetch_ready_i,
    input logic        retire_valid_i
);

    int unsigned fail_cnt = 0;

    // first cycle out of reset
    a_reset_state: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> fetch_valid_i && fetch_addr_i == rv_isa_pkg::RESET_PC
                           && !retire_valid_i)
        else begin
            fail_cnt++;
            $error("core did not fetch from the reset pc after reset");
        end

    a_no_retire_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !retire_valid_i)
        else begin
            fail_cnt++;
            $error("retire pulse right after a reset cycle");
        end

    // request held with a stable address while memory stalls
    a_fetch_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i && !fetch_ready_i |=> fetch_valid_i && $stable(fetch_addr_i))
        else begin
            fail_cnt++;
            $error("fetch request dropped or address changed during a stall");
        end

    a_retire_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_valid_i && fetch_ready_i |-> ##2 retire_valid_i)
        else begin
            fail_cnt++;
            $error("retire did not follow the fetch handshake by two cycles");
        end

    a_retire_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_valid_i |=> !retire_valid_i && fetch_valid_i)
        else begin
            fail_cnt++;
            $error("retire longer than one cycle or no fetch after it");
        end

endmodule

bind rv_core_top rv_core_props i_props (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_valid_i  (fetch_valid_o),
    .fetch_addr_i   (fetch_addr_o),
    .fetch_ready_i  (fetch_ready_i),
    .retire_valid_i (retire_valid_o)
);

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 8;
    localparam int          PROG_LEN   = 64;
    localparam logic [31:0] END_PC     = 32'd252; // self-loop at the last word

    logic                 clk           = 1'b0;
    logic                 rst_n         = 1'b0;
    logic                 fetch_ready   = 1'b0;
    logic [31:0]          fetch_inst;
    logic                 fetch_valid;
    logic [31:0]          fetch_addr;
    logic                 retire_valid;
    rv_core_pkg::retire_t retire;
    logic [31:0]          cycle_count;
    logic [31:0]          instret_count;

    logic [31:0] imem [PROG_LEN];
    logic [31:0] mregs [32];           // reference register file
    logic [31:0] mpc     = 32'd0;      // reference pc
    integer      seed    = 56;
    int          cyc     = 0;
    int          run_cyc = 0;          // cycles since reset release
    int          hs_cyc  = -100;
    int          n_tests = 0;
    int          n_fail  = 0;
    int          n_ret   = 0;
    int          prop_fail;
    logic        done    = 1'b0;

    rv_core_top i_dut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .fetch_valid_o   (fetch_valid),
        .fetch_addr_o    (fetch_addr),
        .fetch_ready_i   (fetch_ready),
        .fetch_inst_i    (fetch_inst),
        .retire_valid_o  (retire_valid),
        .retire_o        (retire),
        .cycle_count_o   (cycle_count),
        .instret_count_o (instret_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign fetch_inst = imem[fetch_addr[7:2]]; // asynchronous rom

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n) begin
            run_cyc <= run_cyc + 1;
        end
        fetch_ready <= done ? 1'b0 : (($random(seed) & 32'h3) != 0); // stalls about 1 in 4
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // architectural result of one instruction against the reference state
    function automatic rv_core_pkg::retire_t model_exec(input logic [31:0] ins,
                                                        input logic [31:0] pc);
        rv_core_pkg::retire_t r;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [31:0]          imm;
        logic                 alt;
        logic                 taken;
        a         = mregs[ins[19:15]];
        b         = mregs[ins[24:20]];
        imm       = {{20{ins[31]}}, ins[31:20]};
        alt       = (ins[31:25] == 7'b0100000);
        taken     = 1'b0;
        r         = '0;
        r.pc      = pc;
        r.next_pc = pc + 32'd4;
        case (ins[6:0])
            rv_isa_pkg::OP_IMM, rv_isa_pkg::OP: begin
                if (ins[5] == 1'b0) begin
                    b = imm; // immediate form, shamt sits in imm[4:0]
                end
                r.wen = 1'b1;
                r.rd  = ins[11:7];
                case (ins[14:12])
                    3'd0:    r.wdata = (ins[5] && alt) ? a - b : a + b;
                    3'd1:    r.wdata = a << b[4:0];
                    3'd2:    r.wdata = {31'b0, $signed(a) < $signed(b)};
                    3'd3:    r.wdata = {31'b0, a < b};
                    3'd4:    r.wdata = a ^ b;
                    3'd5:    r.wdata = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6:    r.wdata = a | b;
                    default: r.wdata = a & b;
                endcase
            end
            rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: begin
                r.wen   = 1'b1;
                r.rd    = ins[11:7];
                r.wdata = {ins[31:12], 12'b0} + (ins[5] ? 32'd0 : pc);
            end
            rv_isa_pkg::JAL: begin
                r.wen     = 1'b1;
                r.rd      = ins[11:7];
                r.wdata   = pc + 32'd4;
                r.next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rv_isa_pkg::JALR: begin
                r.wen     = 1'b1;
                r.rd      = ins[11:7];
                r.wdata   = pc + 32'd4;
                r.next_pc = (a + imm) & ~32'd1;
            end
            rv_isa_pkg::BRANCH: begin
                case (ins[14:12])
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    r.next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: ; // unknown encoding, no write
        endcase
        return r;
    endfunction

    task automatic check_retire();
        rv_core_pkg::retire_t exp;
        int                   bad;
        exp = model_exec(imem[mpc[7:2]], mpc);
        bad = 0;
        assert (retire.pc == exp.pc && retire.next_pc == exp.next_pc) else begin
            $display("CHECK FAILED @%0t: pc %h next_pc %h, expected %h %h", $time,
                     retire.pc, retire.next_pc, exp.pc, exp.next_pc);
            bad++;
        end
        assert (retire.wen == exp.wen
                && (!exp.wen || (retire.rd == exp.rd && retire.wdata == exp.wdata))) else begin
            $display("CHECK FAILED @%0t: pc %h wen %b rd %0d wdata %h, expected %b %0d %h",
                     $time, exp.pc, retire.wen, retire.rd, retire.wdata,
                     exp.wen, exp.rd, exp.wdata);
            bad++;
        end
        assert (cyc == hs_cyc + 2) else begin
            $display("CHECK FAILED @%0t: retire %0d cycles after the fetch handshake, expected 2",
                     $time, cyc - hs_cyc);
            bad++;
        end
        if (exp.wen && exp.rd != 5'd0) begin
            mregs[exp.rd] = exp.wdata;
        end
        mpc = exp.next_pc;
        n_tests++;
        n_ret++;
        if (bad != 0) begin
            n_fail++;
        end
        $display("test %0d pc %h: %s", n_tests, exp.pc, (bad == 0) ? "passed" : "failed");
        if (exp.pc == END_PC) begin
            done = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && !done) begin
            if (retire_valid) begin
                check_retire();
            end
            if (fetch_valid && fetch_ready) begin
                hs_cyc = cyc;
            end
        end
    end

    initial begin
        int         idx;
        logic [2:0] f3;
        logic [4:0] ra;
        logic [4:0] rb;
        for (int k = 0; k < 32; k++) begin
            mregs[k] = 32'd0;
        end
        imem[0]  = u_type(20'h80001, 5'd1, rv_isa_pkg::LUI);
        imem[1]  = i_type(12'hffb, 5'd0, rv_isa_pkg::F3_ADD_SUB, 5'd2, rv_isa_pkg::OP_IMM);
        imem[2]  = i_type(12'h007, 5'd0, rv_isa_pkg::F3_ADD_SUB, 5'd3, rv_isa_pkg::OP_IMM);
        imem[3]  = u_type(20'h00010, 5'd4, rv_isa_pkg::AUIPC);
        imem[4]  = i_type(12'hffc, 5'd2, rv_isa_pkg::F3_SLT, 5'd5, rv_isa_pkg::OP_IMM);
        imem[5]  = i_type(12'hfff, 5'd3, rv_isa_pkg::F3_SLTU, 5'd6, rv_isa_pkg::OP_IMM);
        imem[6]  = i_type(12'h055, 5'd2, rv_isa_pkg::F3_XOR, 5'd7, rv_isa_pkg::OP_IMM);
        imem[7]  = i_type(12'h100, 5'd3, rv_isa_pkg::F3_OR, 5'd8, rv_isa_pkg::OP_IMM);
        imem[8]  = i_type(12'h0f0, 5'd2, rv_isa_pkg::F3_AND, 5'd9, rv_isa_pkg::OP_IMM);
        imem[9]  = i_type(12'h004, 5'd3, rv_isa_pkg::F3_SLL, 5'd10, rv_isa_pkg::OP_IMM);
        imem[10] = i_type(12'h003, 5'd1, rv_isa_pkg::F3_SR, 5'd11, rv_isa_pkg::OP_IMM);
        imem[11] = i_type(12'h403, 5'd1, rv_isa_pkg::F3_SR, 5'd12, rv_isa_pkg::OP_IMM); // srai
        imem[12] = r_type(7'h00, 5'd3, 5'd2, rv_isa_pkg::F3_ADD_SUB, 5'd13);
        imem[13] = r_type(7'h20, 5'd2, 5'd3, rv_isa_pkg::F3_ADD_SUB, 5'd14);
        imem[14] = r_type(7'h00, 5'd2, 5'd3, rv_isa_pkg::F3_SLL, 5'd15); // shift by 27
        imem[15] = r_type(7'h00, 5'd3, 5'd2, rv_isa_pkg::F3_SLT, 5'd16);
        imem[16] = r_type(7'h00, 5'd3, 5'd2, rv_isa_pkg::F3_SLTU, 5'd17);
        imem[17] = r_type(7'h00, 5'd2, 5'd1, rv_isa_pkg::F3_XOR, 5'd18);
        imem[18] = r_type(7'h00, 5'd3, 5'd1, rv_isa_pkg::F3_SR, 5'd19);
        imem[19] = r_type(7'h20, 5'd3, 5'd1, rv_isa_pkg::F3_SR, 5'd20);
        imem[20] = r_type(7'h00, 5'd3, 5'd2, rv_isa_pkg::F3_OR, 5'd21);
        imem[21] = r_type(7'h00, 5'd2, 5'd1, rv_isa_pkg::F3_AND, 5'd22);
        // x0 write, x0 is read back by the branches below
        imem[22] = i_type(12'hffc, 5'd2, rv_isa_pkg::F3_ADD_SUB, 5'd0, rv_isa_pkg::OP_IMM);
        imem[23] = 32'hffff_ffff; // unknown opcode
        // each branch condition on (x2,x3), (x0,x2), (x3,x3), skipping a counter bump
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                f3  = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
                ra  = (p == 0) ? 5'd2 : (p == 1) ? 5'd0 : 5'd3;
                rb  = (p == 1) ? 5'd2 : 5'd3;
                idx = 24 + 2 * (3 * k + p);
                imem[idx]     = b_type(13'd8, rb, ra, f3);
                imem[idx + 1] = i_type(12'h001, 5'd23, rv_isa_pkg::F3_ADD_SUB, 5'd23,
                                       rv_isa_pkg::OP_IMM);
            end
        end
        imem[60] = j_type(21'd8, 5'd24);
        imem[61] = i_type(12'h001, 5'd23, rv_isa_pkg::F3_ADD_SUB, 5'd23, rv_isa_pkg::OP_IMM);
        imem[62] = i_type(12'h009, 5'd24, 3'b000, 5'd25, rv_isa_pkg::JALR); // odd target
        imem[63] = j_type(21'd0, 5'd0);

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (done);
        repeat (3) @(negedge clk);
        n_tests++;
        assert (instret_count == n_ret) else begin
            $display("CHECK FAILED @%0t: instret_count %0d, observed %0d retires", $time,
                     instret_count, n_ret);
            n_fail++;
        end
        $display("test %0d instret count: %s", n_tests,
                 (instret_count == n_ret) ? "passed" : "failed");
        n_tests++;
        assert (cycle_count == run_cyc) else begin
            $display("CHECK FAILED @%0t: cycle_count %0d, expected %0d", $time,
                     cycle_count, run_cyc);
            n_fail++;
        end
        $display("test %0d cycle count: %s", n_tests,
                 (cycle_count == run_cyc) ? "passed" : "failed");
        prop_fail = i_dut.i_props.fail_cnt;
        $display("tests %0d, passed %0d, failed %0d, protocol assertion failures %0d",
                 n_tests, n_tests - n_fail, n_fail, prop_fail);
        if (n_fail == 0 && prop_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + 40 * PROG_LEN) * CLK_PERIOD);
        $display("simulation timed out before program completion");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: all.f
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_ctrl_fsm.sv
src/rv_event_counter.sv
src/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rv_core_tb -f all.f -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
